//--- run.sh
#!/bin/sh
# Builds the vector execute stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_vexec -f sources.f -o sim_vexec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_vexec > "$log" 2>&1
sim_status=$?
cat "$log"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- sources.f
src/vexec_pkg.sv
src/lane_if.sv
src/operand_router.sv
src/vector_lane.sv
src/exec_latch.sv
src/vexec_top.sv
tests/vexec_sva.sv
tests/tb_vexec.sv

//--- src/exec_latch.sv
// Execute to memory pipeline latch
// Merges both lanes into the EX/MEM register, choosing addresses for
// loads and stores and ALU results otherwise
`timescale 1ns/1ps

module exec_latch (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             valid,
  input  logic             ls,
  input  logic             stall,
  input  logic             flush,
  lane_if.sink             l0,
  lane_if.sink             l1,
  output vexec_pkg::word_t res0,
  output vexec_pkg::word_t res1,
  output logic             wen0,
  output logic             wen1,
  output logic             ls_out
);

  vexec_pkg::word_t next_res0;
  vexec_pkg::word_t next_res1;
  logic             next_wen0;
  logic             next_wen1;
  logic             next_ls;

  // Address for memory ops, element result for register writes
  assign next_res0 = ls ? l0.in_addr : l0.result;
  assign next_res1 = ls ? l1.in_addr : l1.result;

  // Register writeback only for active, unmasked ALU elements
  assign next_wen0 = valid & l0.mask & ~ls;
  assign next_wen1 = valid & l1.mask & ~ls;
  assign next_ls   = valid & ls;

  // Flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      res0   <= '0;
      res1   <= '0;
      wen0   <= 1'b0;
      wen1   <= 1'b0;
      ls_out <= 1'b0;
    end else if (flush) begin
      res0   <= '0;
      res1   <= '0;
      wen0   <= 1'b0;
      wen1   <= 1'b0;
      ls_out <= 1'b0;
    end else if (!stall) begin
      res0   <= next_res0;
      res1   <= next_res1;
      wen0   <= next_wen0;
      wen1   <= next_wen1;
      ls_out <= next_ls;
    end
  end

endmodule

//--- src/lane_if.sv
// Lane bundle
// Operands and controls from the router into one vector lane, and the
// lane's result and address on to the execute/memory latch
`timescale 1ns/1ps

interface lane_if;

  vexec_pkg::word_t   op_a;
  vexec_pkg::word_t   op_b;
  vexec_pkg::word_t   in_addr;
  vexec_pkg::word_t   stride;
  vexec_pkg::alu_op_t op;
  logic               mask;
  vexec_pkg::word_t   result;
  vexec_pkg::word_t   out_addr;

  modport router (
    output op_a, op_b, in_addr, stride, op, mask,
    input  out_addr
  );

  modport lane (
    input  op_a, op_b, in_addr, stride, op, mask,
    output result, out_addr
  );

  modport sink (
    input result, in_addr, out_addr, mask
  );

endinterface

//--- src/operand_router.sv
// Operand router for the two vector lanes
// Picks each lane's operands by source type, forms the stride and keeps
// the running load/store address between element pairs
`timescale 1ns/1ps

module operand_router (
  input  logic               CLK,
  input  logic               nRST,
  input  vexec_pkg::alu_op_t op,
  input  vexec_pkg::src_t    rs1_type,
  input  vexec_pkg::src_t    rs2_type,
  input  vexec_pkg::word_t   vs1_lane0,
  input  vexec_pkg::word_t   vs1_lane1,
  input  vexec_pkg::word_t   vs2_lane0,
  input  vexec_pkg::word_t   vs2_lane1,
  input  vexec_pkg::word_t   imm,
  input  vexec_pkg::word_t   xs1,
  input  vexec_pkg::word_t   xs2,
  input  vexec_pkg::word_t   stride_val,
  input  logic               mask0,
  input  logic               mask1,
  input  logic               ls,
  input  logic               first,
  input  logic               stride_type,
  input  logic               stall,
  lane_if.router             l0,
  lane_if.router             l1
);

  vexec_pkg::word_t addr_buf;

  // Operand a
  always_comb begin
    case (rs1_type)
      vexec_pkg::SRC_V: begin
        l0.op_a = vs1_lane0;
        l1.op_a = vs1_lane1;
      end
      vexec_pkg::SRC_I: begin
        l0.op_a = imm;
        l1.op_a = imm;
      end
      vexec_pkg::SRC_X: begin
        l0.op_a = xs1;
        l1.op_a = xs1;
      end
      default: begin
        l0.op_a = '0;
        l1.op_a = '0;
      end
    endcase
  end

  // Operand b
  always_comb begin
    case (rs2_type)
      vexec_pkg::SRC_V: begin
        l0.op_b = vs2_lane0;
        l1.op_b = vs2_lane1;
      end
      vexec_pkg::SRC_I: begin
        l0.op_b = imm;
        l1.op_b = imm;
      end
      vexec_pkg::SRC_X: begin
        l0.op_b = xs2;
        l1.op_b = xs2;
      end
      default: begin
        l0.op_b = '0;
        l1.op_b = '0;
      end
    endcase
  end

  assign l0.op   = op;
  assign l1.op   = op;
  assign l0.mask = mask0;
  assign l1.mask = mask1;

  // Same stride for both lanes
  assign l0.stride = stride_type ? stride_val : vexec_pkg::DEFAULT_STRIDE;
  assign l1.stride = stride_type ? stride_val : vexec_pkg::DEFAULT_STRIDE;

  // Lane 0 starts at the base on the first pair, lane 1 chains off lane 0
  assign l0.in_addr = first ? xs1 : addr_buf;
  assign l1.in_addr = l0.out_addr;

  // Running address for the next element pair, frozen under stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buf <= '0;
    end else if (ls && !stall) begin
      addr_buf <= l1.out_addr;
    end
  end

endmodule

//--- src/vector_lane.sv
// Single vector lane
// Eight-operation integer ALU gated by the lane mask, with a strided
// address adder alongside for loads and stores
`timescale 1ns/1ps

module vector_lane (
  lane_if.lane lif
);

  vexec_pkg::word_t  alu_out;
  vexec_pkg::shamt_t shamt;
  logic              a_lt_b;

  // Only the low five bits of b shift a 32-bit word
  assign shamt = vexec_pkg::shamt_t'(lif.op_b[4:0]);

  // Signed compare for MIN
  assign a_lt_b = $signed(lif.op_a) < $signed(lif.op_b);

  always_comb begin
    case (lif.op)
      vexec_pkg::ADD: begin
        alu_out = lif.op_a + lif.op_b;
      end
      vexec_pkg::SUB: begin
        alu_out = lif.op_a - lif.op_b;
      end
      vexec_pkg::AND: begin
        alu_out = lif.op_a & lif.op_b;
      end
      vexec_pkg::OR: begin
        alu_out = lif.op_a | lif.op_b;
      end
      vexec_pkg::XOR: begin
        alu_out = lif.op_a ^ lif.op_b;
      end
      vexec_pkg::SLL: begin
        alu_out = lif.op_a << shamt;
      end
      vexec_pkg::SRL: begin
        // Logical, zero fill
        alu_out = lif.op_a >> shamt;
      end
      vexec_pkg::MIN: begin
        alu_out = a_lt_b ? lif.op_a : lif.op_b;
      end
      default: begin
        alu_out = '0;
      end
    endcase
  end

  // Masked-off elements produce zero
  assign lif.result = lif.mask ? alu_out : '0;

  // Next element address
  assign lif.out_addr = lif.in_addr + lif.stride;

endmodule

//--- src/vexec_pkg.sv
// Vector execute stage shared types
// Element and address widths, ALU operation codes, operand source
// codes and the default load/store stride
package vexec_pkg;

  // One 32-bit element or byte address
  typedef logic [31:0] word_t;

  // Shift amount taken from the low bits of operand b
  typedef logic [4:0] shamt_t;

  // Integer operations run by each lane
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    MIN = 3'd7   // signed minimum
  } alu_op_t;

  // Operand source as given by decode
  typedef enum logic [1:0] {
    SRC_V    = 2'd0,  // per-lane vector register value
    SRC_I    = 2'd1,  // immediate, shared by both lanes
    SRC_X    = 2'd2,  // scalar register, shared by both lanes
    SRC_NONE = 2'd3   // constant zero
  } src_t;

  // Unit stride for 32-bit elements
  localparam word_t DEFAULT_STRIDE = 32'd4;

endpackage

//--- src/vexec_top.sv
// Two-lane vector execute stage
// Operand router feeding two vector lanes, merged into the EX/MEM latch
`timescale 1ns/1ps

module vexec_top (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               valid,
  input  vexec_pkg::alu_op_t op,
  input  vexec_pkg::src_t    rs1_type,
  input  vexec_pkg::src_t    rs2_type,
  input  vexec_pkg::word_t   vs1_lane0,
  input  vexec_pkg::word_t   vs1_lane1,
  input  vexec_pkg::word_t   vs2_lane0,
  input  vexec_pkg::word_t   vs2_lane1,
  input  vexec_pkg::word_t   imm,
  input  vexec_pkg::word_t   xs1,
  input  vexec_pkg::word_t   xs2,
  input  logic               mask0,
  input  logic               mask1,
  input  logic               ls,
  input  logic               first,
  input  logic               stride_type,
  input  vexec_pkg::word_t   stride_val,
  input  logic               stall,
  input  logic               flush,
  output vexec_pkg::word_t   res0,
  output vexec_pkg::word_t   res1,
  output logic               wen0,
  output logic               wen1,
  output logic               ls_out
);

  lane_if lane0_if ();
  lane_if lane1_if ();

  operand_router u_router (
    .CLK         (CLK),
    .nRST        (nRST),
    .op          (op),
    .rs1_type    (rs1_type),
    .rs2_type    (rs2_type),
    .vs1_lane0   (vs1_lane0),
    .vs1_lane1   (vs1_lane1),
    .vs2_lane0   (vs2_lane0),
    .vs2_lane1   (vs2_lane1),
    .imm         (imm),
    .xs1         (xs1),
    .xs2         (xs2),
    .stride_val  (stride_val),
    .mask0       (mask0),
    .mask1       (mask1),
    .ls          (ls),
    .first       (first),
    .stride_type (stride_type),
    .stall       (stall),
    .l0          (lane0_if),
    .l1          (lane1_if)
  );

  vector_lane u_lane0 (.lif(lane0_if));
  vector_lane u_lane1 (.lif(lane1_if));

  exec_latch u_latch (
    .CLK    (CLK),
    .nRST   (nRST),
    .valid  (valid),
    .ls     (ls),
    .stall  (stall),
    .flush  (flush),
    .l0     (lane0_if),
    .l1     (lane1_if),
    .res0   (res0),
    .res1   (res1),
    .wen0   (wen0),
    .wen1   (wen1),
    .ls_out (ls_out)
  );

endmodule

//--- tests/tb_vexec.sv
// Testbench for the two-lane vector execute stage
// Drives ALU, masking, strided address, stall and flush traffic and
// checks the EX/MEM latch outputs against a reference model
`timescale 1ns/1ps

module tb_vexec;

  localparam int STIM_CYCLES = 105;
  localparam vexec_pkg::word_t UNIT_STRIDE = 32'd4;

  // Expected EX/MEM latch contents
  typedef struct packed {
    vexec_pkg::word_t res0;
    vexec_pkg::word_t res1;
    logic             wen0;
    logic             wen1;
    logic             ls_out;
  } latch_t;

  logic CLK, nRST, valid, mask0, mask1, ls, first, stride_type, stall, flush;
  logic wen0, wen1, ls_out;
  vexec_pkg::alu_op_t op;
  vexec_pkg::src_t rs1_type, rs2_type;
  vexec_pkg::word_t vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1, imm, xs1, xs2;
  vexec_pkg::word_t stride_val, res0, res1, ref_buf;
  latch_t exp_q;
  string test_name = "reset";
  string last_name = "reset";
  int err_cnt = 0;
  int check_cnt = 0;
  int cycle_cnt;

  vexec_top u_vexec_top (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Twice the stimulus length before giving up
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < 2 * STIM_CYCLES) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout: run still going after %0d cycles", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic vexec_pkg::word_t sel_operand(input vexec_pkg::src_t s,
      input vexec_pkg::word_t lane_val, input vexec_pkg::word_t imm_val,
      input vexec_pkg::word_t x_val);
    return (s == vexec_pkg::SRC_V) ? lane_val : (s == vexec_pkg::SRC_I) ? imm_val :
        (s == vexec_pkg::SRC_X) ? x_val : 32'd0;
  endfunction

  // Expected element result of one lane
  function automatic vexec_pkg::word_t ref_lane(input vexec_pkg::alu_op_t f,
      input vexec_pkg::word_t a, input vexec_pkg::word_t b, input logic m);
    if (!m) begin
      return 32'd0;
    end
    case (f)
      vexec_pkg::ADD: return a + b;
      vexec_pkg::SUB: return a - b;
      vexec_pkg::AND: return a & b;
      vexec_pkg::OR:  return a | b;
      vexec_pkg::XOR: return a ^ b;
      vexec_pkg::SLL: return a << b[4:0];
      vexec_pkg::SRL: return a >> b[4:0];
      default:        return ($signed(a) < $signed(b)) ? a : b;
    endcase
  endfunction

  task automatic check_word(input string tname, input string sig,
      input vexec_pkg::word_t expv, input vexec_pkg::word_t actv);
    check_cnt++;
    if (actv !== expv) begin
      err_cnt++;
      $display("FAIL %s %s: expected %h, actual %h", tname, sig, expv, actv);
    end
  endtask

  task automatic check_bit(input string tname, input string sig,
      input logic expv, input logic actv);
    check_cnt++;
    if (actv !== expv) begin
      err_cnt++;
      $display("FAIL %s %s: expected %b, actual %b", tname, sig, expv, actv);
    end
  endtask

  // Reference latch and address buffer updated on the DUT's clock edge
  always @(posedge CLK or negedge nRST) begin : ref_model
    vexec_pkg::word_t strd, addr0, addr1;
    strd = stride_type ? stride_val : UNIT_STRIDE;
    addr0 = first ? xs1 : ref_buf;
    addr1 = addr0 + strd;
    if (!nRST || flush) begin
      exp_q = '0;
    end else if (!stall) begin
      exp_q.res0 = ls ? addr0 : ref_lane(op, sel_operand(rs1_type, vs1_lane0, imm, xs1),
          sel_operand(rs2_type, vs2_lane0, imm, xs2), mask0);
      exp_q.res1 = ls ? addr1 : ref_lane(op, sel_operand(rs1_type, vs1_lane1, imm, xs1),
          sel_operand(rs2_type, vs2_lane1, imm, xs2), mask1);
      exp_q.wen0 = valid && mask0 && !ls;
      exp_q.wen1 = valid && mask1 && !ls;
      exp_q.ls_out = valid && ls;
    end
    // Next pair starts two strides past lane 0
    if (!nRST) begin
      ref_buf = 32'd0;
    end else if (ls && !stall) begin
      ref_buf = addr1 + strd;
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge CLK) begin
    check_word(last_name, "res0", exp_q.res0, res0);
    check_word(last_name, "res1", exp_q.res1, res1);
    check_bit(last_name, "wen0", exp_q.wen0, wen0);
    check_bit(last_name, "wen1", exp_q.wen1, wen1);
    check_bit(last_name, "ls_out", exp_q.ls_out, ls_out);
    last_name = test_name;
  end

  // Random element pair with both masks set and no memory access
  task automatic load_inputs(input string name, input logic st, input logic fl);
    test_name = name;
    valid <= 1'b1;
    op <= vexec_pkg::alu_op_t'(3'($urandom));
    rs1_type <= vexec_pkg::src_t'(2'($urandom));
    rs2_type <= vexec_pkg::src_t'(2'($urandom));
    {vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1} <= {$urandom, $urandom, $urandom, $urandom};
    {imm, xs1, xs2} <= {$urandom, $urandom, $urandom};
    {mask0, mask1, ls, first, stride_type} <= 5'b11000;
    {stall, flush} <= {st, fl};
  endtask

  initial begin : stimulus
    int unsigned seed;
    seed = $urandom(13222);
    nRST <= 1'b0;
    stride_val <= 32'd0;
    load_inputs("reset", 1'b0, 1'b0);
    valid <= 1'b0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    // All eight operations in turn, then every mask pattern
    for (int i = 0; i < 76; i++) begin
      @(posedge CLK);
      if (i < 64) begin
        load_inputs("operands", 1'b0, 1'b0);
        op <= vexec_pkg::alu_op_t'(3'(i));
      end else begin
        load_inputs("masking", 1'b0, 1'b0);
        {mask0, mask1} <= 2'(i);
      end
    end
    // Default stride, explicit stride, then an access stalled mid-chain
    for (int i = 0; i < 16; i++) begin
      @(posedge CLK);
      load_inputs((i < 8) ? "address" : "stall", (i >= 10) && (i < 13), 1'b0);
      {ls, first, stride_type} <= {1'b1, (i % 4 == 0) && (i < 12), i >= 4};
      if (i % 4 == 0) begin
        stride_val <= {22'd0, 8'($urandom), 2'b00};
      end
    end
    // Flush alone, then flush and stall together
    for (int i = 0; i < 8; i++) begin
      @(posedge CLK);
      load_inputs("flush", (i == 4) || (i == 5), (i == 2) || (i == 4));
      ls <= i[0];
    end
    @(posedge CLK);
    valid <= 1'b0;
    // The last compare runs on the falling edge before this
    repeat (2) @(posedge CLK);
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tests/vexec_sva.sv
// EX/MEM latch checks
// Bound into the latch to watch flush, stall and enable behaviour
`timescale 1ns/1ps

module vexec_sva (
  input logic             CLK,
  input logic             nRST,
  input logic             stall,
  input logic             flush,
  input vexec_pkg::word_t res0,
  input logic             wen0,
  input logic             wen1,
  input logic             ls_out
);

  // Flushed latch issues no write or access
  assert property (@(posedge CLK) disable iff (!nRST) flush |=> !(wen0 || wen1 || ls_out))
    else $error("enable high in the cycle after a flush");

  // Loads and stores never write the register file
  assert property (@(posedge CLK) disable iff (!nRST) !(ls_out && (wen0 || wen1)))
    else $error("ls_out and a write enable high together");

  // Stall without flush freezes the latch
  assert property (@(posedge CLK) disable iff (!nRST) stall && !flush |=> $stable(res0))
    else $error("res0 changed under stall");

endmodule

bind exec_latch vexec_sva u_sva (.*);
